// File: include/sdmac_defines.svh
// ------------------------------
// sdmac datapath widths
// word, byte and FIFO sizing for
// the SCSI DMA data path
// ------------------------------

`ifndef SDMAC_DEFINES_SVH
`define SDMAC_DEFINES_SVH

// host side word width
`define SDMAC_WORD_W 32

// one SCSI byte lane
`define SDMAC_BYTE_W 8

// default FIFO entries, power of two
`define SDMAC_FIFO_DEPTH 8

`endif

// File: verilog/sdmac_pkg.sv
// ------------------------------
// sdmac_pkg
// shared enums and structs of the
// SCSI DMA data path
// ------------------------------

package sdmac_pkg;

    // direction latched when a DMA starts
    typedef enum logic {
        DIR_TO_SCSI   = 1'b0,
        DIR_FROM_SCSI = 1'b1
    } dma_dir_e;

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        // one cycle to drop a partial word
        ST_FLUSH = 2'd2
    } dma_state_e;

    // strobes into the SCSI byte path
    typedef struct packed {
        // sequencer driven
        logic f2s;
        logic s2f;
        // host driven
        logic cpu2s;
        logic s2cpu;
        logic ls2cpu;
    } scsi_ctl_t;

    // FIFO fill state
    typedef struct packed {
        logic empty;
        logic full;
    } fifo_stat_t;

endpackage

// File: verilog/dma_fifo.sv
// ------------------------------
// dma_fifo
// word FIFO, whole-word or byte-lane
// fill at the tail, word pop at head
// ------------------------------

`timescale 1ns/1ps

`include "sdmac_defines.svh"

module dma_fifo #(
    parameter int depth = `SDMAC_FIFO_DEPTH
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       push_word,
    input  logic [`SDMAC_WORD_W-1:0]                   push_data,
    input  logic [`SDMAC_WORD_W/`SDMAC_BYTE_W-1:0]     lane_we,
    input  logic [`SDMAC_WORD_W-1:0]                   lane_data,
    input  logic                                       commit,
    input  logic                                       pop,
    output logic [`SDMAC_WORD_W-1:0]                   head,
    output sdmac_pkg::fifo_stat_t                      stat
);

    localparam int ptr_w = $clog2(depth);
    localparam int lanes = `SDMAC_WORD_W / `SDMAC_BYTE_W;

    // entry storage
    logic [`SDMAC_WORD_W-1:0] mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    // one extra bit so full and empty differ
    logic [ptr_w:0]   count;
    logic             advance;
    logic             fifo_empty;
    logic             fifo_full;

    // tail moves on a host word or a packed word
    assign advance = push_word | commit;

    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == (ptr_w + 1)'(depth));

    // tail write
    // host word takes the whole entry while the packer fills single lanes
    always_ff @(posedge clk) begin
        if (push_word) begin
            mem[wr_ptr] <= push_data;
        end else begin
            for (int i = 0; i < lanes; i++) begin
                if (lane_we[i]) begin
                    mem[wr_ptr][i*`SDMAC_BYTE_W +: `SDMAC_BYTE_W] <=
                        lane_data[i*`SDMAC_BYTE_W +: `SDMAC_BYTE_W];
                end
            end
        end
    end

    // pointers and fill count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // depth is a power of two so pointers wrap by themselves
            if (advance) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({advance, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head is visible without a read cycle
    assign head = mem[rd_ptr];

    assign stat.empty = fifo_empty;
    assign stat.full  = fifo_full;

    // host and sequencer both have to respect full
    a_no_push_full : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(advance && fifo_full)
    ) else $error("dma_fifo: push or commit while full");

    // host pop and sequencer pop share this strobe
    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(pop && fifo_empty)
    ) else $error("dma_fifo: pop while empty");

    // host words must not land while a packed word completes
    a_no_push_commit : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(push_word && commit)
    ) else $error("dma_fifo: push_word together with commit");

endmodule

// File: verilog/dma_sequencer.sv
// ------------------------------
// dma_sequencer
// DMA FSM, byte pointer and FIFO
// strobes for F2S and S2F moves
// ------------------------------

`timescale 1ns/1ps

module dma_sequencer (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  dma_go,
    input  logic                  dma_stop,
    input  sdmac_pkg::dma_dir_e   dir,
    input  logic                  scsi_req,
    input  sdmac_pkg::fifo_stat_t stat,
    output logic                  f2s,
    output logic                  s2f,
    output logic [1:0]            bo,
    output logic [3:0]            lane_we,
    output logic                  commit,
    output logic                  pop
);

    import sdmac_pkg::*;

    dma_state_e state;
    dma_state_e state_nxt;
    dma_dir_e   dir_q;

    logic       running;
    // a req that is actually consumed
    logic       take;
    // pointer on the top lane of the word
    logic       last_byte;

    // state register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // go only starts from idle and stop always passes through flush
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (dma_go) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (dma_stop) begin
                    state_nxt = ST_FLUSH;
                end
            end
            ST_FLUSH: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // direction sampled with the go pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dir_q <= DIR_TO_SCSI;
        end else if (state == ST_IDLE && dma_go) begin
            dir_q <= dir;
        end
    end

    assign running = (state == ST_RUN);

    // strobes drop under back-pressure, which also masks scsi_req
    assign f2s = running && (dir_q == DIR_TO_SCSI) && !stat.empty;
    assign s2f = running && (dir_q == DIR_FROM_SCSI) && !stat.full;

    assign take      = scsi_req && (f2s || s2f);
    assign last_byte = (bo == 2'd3);

    // byte pointer
    // flush and a fresh start both restart at lane 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bo <= 2'd0;
        end else if (state == ST_FLUSH) begin
            bo <= 2'd0;
        end else if (state == ST_IDLE && dma_go) begin
            bo <= 2'd0;
        end else if (take) begin
            // wraps from 3 to 0 with the word boundary
            bo <= bo + 2'd1;
        end
    end

    // receive side fills one lane per accepted byte
    assign lane_we = (s2f && scsi_req) ? (4'b0001 << bo) : 4'b0000;

    // word boundary actions
    assign commit = s2f && scsi_req && last_byte;
    assign pop    = f2s && scsi_req && last_byte;

    // only one direction can drive the byte path
    a_one_dir : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(f2s && s2f)
    ) else $error("dma_sequencer: f2s and s2f both high");

endmodule

// File: verilog/datapath_scsi.sv
// ------------------------------
// datapath_scsi
// SCSI byte path, transmit mux,
// receive gate and programmed read
// ------------------------------

`timescale 1ns/1ps

`include "sdmac_defines.svh"

module datapath_scsi (
    input  logic                         clk,
    input  logic                         arst_n,
    input  sdmac_pkg::scsi_ctl_t         ctl,
    input  logic                         a3,
    input  logic [1:0]                   bo,
    input  logic [`SDMAC_WORD_W-1:0]     fifo_od,
    input  logic [`SDMAC_WORD_W-1:0]     cpu_od,
    input  logic [2*`SDMAC_BYTE_W-1:0]   scsi_data_in,
    output logic [2*`SDMAC_BYTE_W-1:0]   scsi_data_out,
    output logic                         scsi_oe,
    output logic [`SDMAC_WORD_W-1:0]     scsi_od,
    output logic [`SDMAC_WORD_W-1:0]     mod_scsi
);

    localparam int lanes = `SDMAC_WORD_W / `SDMAC_BYTE_W;

    logic [lanes-1:0]         lane_sel;
    // four fifo lanes, cpu high byte, cpu low byte
    logic [lanes+1:0]         tx_sel;
    logic [`SDMAC_BYTE_W-1:0] tx_byte;
    logic                     rx_en;
    logic [`SDMAC_BYTE_W-1:0] rx_byte;
    logic [`SDMAC_BYTE_W-1:0] cap_byte;
    logic [`SDMAC_BYTE_W-1:0] mod_byte;
    logic                     cap_seq;
    logic                     clr_seq;
    logic                     cap_live;

    // lane decode of bo, programmed write takes priority
    assign lane_sel = (ctl.f2s && !ctl.cpu2s) ? (lanes'(1) << bo) : '0;

    assign tx_sel = {ctl.cpu2s & ~a3, ctl.cpu2s & a3, lane_sel};

    // one-hot and-or mux, six byte sources
    always_comb begin
        tx_byte = '0;
        for (int i = 0; i < lanes; i++) begin
            tx_byte = tx_byte |
                ({`SDMAC_BYTE_W{tx_sel[i]}} & fifo_od[i*`SDMAC_BYTE_W +: `SDMAC_BYTE_W]);
        end
        tx_byte = tx_byte | ({`SDMAC_BYTE_W{tx_sel[lanes]}} & cpu_od[23:16]);
        tx_byte = tx_byte | ({`SDMAC_BYTE_W{tx_sel[lanes+1]}} & cpu_od[7:0]);
    end

    // drive the bus only while sending
    assign scsi_oe       = ctl.f2s | ctl.cpu2s;
    assign scsi_data_out = scsi_oe ? {tx_byte, tx_byte} : '0;

    // low half of the bus carries the byte, upper half ignored
    assign rx_en   = ctl.s2f | ctl.s2cpu;
    assign rx_byte = rx_en ? scsi_data_in[`SDMAC_BYTE_W-1:0] : '0;

    // every lane sees the same byte, the FIFO lane enable picks one
    assign scsi_od = {lanes{rx_byte}};

    // programmed read latch
    // byte sampled on the falling edge while ls2cpu is low
    always_ff @(negedge clk) begin
        if (ctl.s2cpu && !ctl.ls2cpu) begin
            cap_byte <= rx_byte;
        end
    end

    // capture and clear live on opposite edges
    // each side owns one toggle, latch is live while they differ
    always_ff @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cap_seq <= 1'b0;
        end else if (ctl.s2cpu && !ctl.ls2cpu && !cap_live) begin
            cap_seq <= ~cap_seq;
        end
    end

    // rising edge with s2cpu low retires the capture
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clr_seq <= 1'b0;
        end else if (!ctl.s2cpu) begin
            clr_seq <= cap_seq;
        end
    end

    assign cap_live = cap_seq ^ clr_seq;
    assign mod_byte = cap_live ? cap_byte : '0;

    // byte in lanes 0 and 2, zero in 1 and 3
    assign mod_scsi = {(lanes/2){{`SDMAC_BYTE_W{1'b0}}, mod_byte}};

    // host programmed write must wait for the DMA to finish
    a_cpu2s_idle : assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ctl.cpu2s && (ctl.f2s || ctl.s2f))
    ) else $error("datapath_scsi: cpu2s during a DMA transfer");

endmodule

// File: verilog/sdmac_datapath_top.sv
// ------------------------------
// sdmac_datapath_top
// FIFO, sequencer and SCSI byte path
// ------------------------------

`timescale 1ns/1ps

`include "sdmac_defines.svh"

module sdmac_datapath_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [`SDMAC_WORD_W-1:0]     cpu_wdata,
    input  logic                         cpu_wr,
    input  logic                         cpu_rd,
    output logic [`SDMAC_WORD_W-1:0]     cpu_rdata,
    input  logic                         cpu2s,
    input  logic                         s2cpu,
    input  logic                         ls2cpu,
    input  logic                         a3,
    input  logic                         dma_go,
    input  logic                         dma_stop,
    input  sdmac_pkg::dma_dir_e          dir,
    input  logic                         scsi_req,
    input  logic [2*`SDMAC_BYTE_W-1:0]   scsi_data_in,
    output logic [2*`SDMAC_BYTE_W-1:0]   scsi_data_out,
    output logic                         scsi_oe,
    output logic [`SDMAC_WORD_W-1:0]     mod_scsi,
    output logic                         fifo_empty,
    output logic                         fifo_full
);

    import sdmac_pkg::*;

    scsi_ctl_t                ctl;
    fifo_stat_t               stat;
    logic                     f2s;
    logic                     s2f;
    logic [1:0]               bo;
    logic [3:0]               lane_we;
    logic                     commit;
    logic                     seq_pop;
    logic                     fifo_pop;
    logic [`SDMAC_WORD_W-1:0] fifo_od;
    logic [`SDMAC_WORD_W-1:0] scsi_od;

    // host read and F2S drain share the head
    assign fifo_pop = cpu_rd | seq_pop;

    assign ctl = '{f2s: f2s, s2f: s2f, cpu2s: cpu2s, s2cpu: s2cpu, ls2cpu: ls2cpu};

    assign cpu_rdata  = fifo_od;
    assign fifo_empty = stat.empty;
    assign fifo_full  = stat.full;

    dma_fifo u_dma_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push_word (cpu_wr),
        .push_data (cpu_wdata),
        .lane_we   (lane_we),
        .lane_data (scsi_od),
        .commit    (commit),
        .pop       (fifo_pop),
        .head      (fifo_od),
        .stat      (stat)
    );

    dma_sequencer u_dma_sequencer (
        .clk      (clk),
        .arst_n   (arst_n),
        .dma_go   (dma_go),
        .dma_stop (dma_stop),
        .dir      (dir),
        .scsi_req (scsi_req),
        .stat     (stat),
        .f2s      (f2s),
        .s2f      (s2f),
        .bo       (bo),
        .lane_we  (lane_we),
        .commit   (commit),
        .pop      (seq_pop)
    );

    // host word doubles as the programmed write source
    datapath_scsi u_datapath_scsi (
        .clk           (clk),
        .arst_n        (arst_n),
        .ctl           (ctl),
        .a3            (a3),
        .bo            (bo),
        .fifo_od       (fifo_od),
        .cpu_od        (cpu_wdata),
        .scsi_data_in  (scsi_data_in),
        .scsi_data_out (scsi_data_out),
        .scsi_oe       (scsi_oe),
        .scsi_od       (scsi_od),
        .mod_scsi      (mod_scsi)
    );

endmodule

// File: sim/tb_sdmac.sv
// ------------------------------
// tb_sdmac
// testbench for the SCSI DMA data
// path, F2S, S2F and programmed I/O
// ------------------------------

`timescale 1ns/1ps

`include "sdmac_defines.svh"

module tb_sdmac;

    import sdmac_pkg::*;

    localparam int cond_tx   = 0;
    localparam int cond_room = 1;
    localparam int cond_data = 2;

    logic                       clk;
    logic                       arst_n;
    logic [`SDMAC_WORD_W-1:0]   cpu_wdata;
    logic                       cpu_wr;
    logic                       cpu_rd;
    logic [`SDMAC_WORD_W-1:0]   cpu_rdata;
    logic                       cpu2s;
    logic                       s2cpu;
    logic                       ls2cpu;
    logic                       a3;
    logic                       dma_go;
    logic                       dma_stop;
    dma_dir_e                   dir;
    logic                       scsi_req;
    logic [2*`SDMAC_BYTE_W-1:0] scsi_data_in;
    logic [2*`SDMAC_BYTE_W-1:0] scsi_data_out;
    logic                       scsi_oe;
    logic [`SDMAC_WORD_W-1:0]   mod_scsi;
    logic                       fifo_empty;
    logic                       fifo_full;

    // expected values armed by the stimulus one edge ahead
    logic                       chk_idle;
    logic                       chk_tx;
    logic [`SDMAC_BYTE_W-1:0]   exp_tx;
    logic [`SDMAC_WORD_W-1:0]   exp_word;
    logic                       chk_mod;
    logic [`SDMAC_BYTE_W-1:0]   exp_mod;
    logic                       chk_full;
    logic                       chk_empty;

    integer                     seed;
    // byte stream model, also the FIFO contents in S2F
    logic [`SDMAC_BYTE_W-1:0]   byte_q[$];

    sdmac_datapath_top UUT (.*);

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Mismatch at %0t: %s expected %h, got %h", $time, sig, exp, act);
        abort_run();
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        abort_run();
    endtask

    function automatic logic status_ready(input int cond);
        case (cond)
            cond_tx:   return scsi_oe;
            cond_room: return !fifo_full;
            default:   return !fifo_empty;
        endcase
    endfunction

    // polled on the falling edge, where outputs have settled
    task automatic wait_until(input int cond, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!status_ready(cond) && n < 64) begin
            @(negedge clk);
            n++;
        end
        if (!status_ready(cond)) begin
            report_error({"timeout waiting for ", what});
        end
    endtask

    task automatic pulse_go(input dma_dir_e d);
        @(posedge clk);
        dir    <= d;
        dma_go <= 1'b1;
        @(posedge clk);
        dma_go <= 1'b0;
    endtask

    task automatic pulse_stop();
        @(posedge clk);
        dma_stop <= 1'b1;
        @(posedge clk);
        dma_stop <= 1'b0;
        // flush cycle then idle
        repeat (2) @(posedge clk);
    endtask

    // F2S byte checked on the edge that takes it
    task automatic take_tx_byte(input logic [7:0] b);
        wait_until(cond_tx, "scsi_oe during F2S");
        @(posedge clk);
        scsi_req <= 1'b1;
        chk_tx   <= 1'b1;
        exp_tx   <= b;
        @(posedge clk);
        scsi_req <= 1'b0;
        chk_tx   <= 1'b0;
    endtask

    // S2F byte after a random gap
    // taken tells whether the FIFO had room
    task automatic send_rx_byte(input logic [7:0] b, output logic taken);
        int gap;
        gap = $random(seed) & 32'h3;
        repeat (gap) @(posedge clk);
        @(negedge clk);
        taken = !fifo_full;
        @(posedge clk);
        scsi_req     <= 1'b1;
        // upper half is noise and only the low byte counts
        scsi_data_in <= {8'($random(seed)), b};
        @(posedge clk);
        scsi_req <= 1'b0;
    endtask

    task automatic pop_word(input logic [31:0] w);
        @(posedge clk);
        cpu_rd   <= 1'b1;
        exp_word <= w;
        @(posedge clk);
        cpu_rd <= 1'b0;
    endtask

    // next four accepted bytes packed lowest lane first
    task automatic read_packed_word();
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[i*8 +: 8] = byte_q.pop_front();
        end
        wait_until(cond_data, "a packed word in the FIFO");
        pop_word(w);
    endtask

    a_idle_oe : assert property (@(posedge clk) disable iff (!arst_n)
        chk_idle |-> !scsi_oe)
        else report_mismatch("scsi_oe", 32'd0, 32'($sampled(scsi_oe)));

    a_idle_out : assert property (@(posedge clk) disable iff (!arst_n)
        chk_idle |-> (scsi_data_out == '0))
        else report_mismatch("scsi_data_out", 32'd0, {16'h0, $sampled(scsi_data_out)});

    a_idle_mod : assert property (@(posedge clk) disable iff (!arst_n)
        chk_idle |-> (mod_scsi == '0))
        else report_mismatch("mod_scsi", 32'd0, $sampled(mod_scsi));

    a_empty : assert property (@(posedge clk) disable iff (!arst_n)
        (chk_idle || chk_empty) |-> fifo_empty)
        else report_mismatch("fifo_empty", 32'd1, 32'($sampled(fifo_empty)));

    a_full : assert property (@(posedge clk) disable iff (!arst_n)
        chk_full |-> fifo_full)
        else report_mismatch("fifo_full", 32'd1, 32'($sampled(fifo_full)));

    a_tx_oe : assert property (@(posedge clk) disable iff (!arst_n)
        chk_tx |-> scsi_oe)
        else report_mismatch("scsi_oe", 32'd1, 32'($sampled(scsi_oe)));

    // byte doubled into both halves of the bus
    a_tx_data : assert property (@(posedge clk) disable iff (!arst_n)
        chk_tx |-> (scsi_data_out == {exp_tx, exp_tx}))
        else report_mismatch("scsi_data_out", {16'h0, $sampled(exp_tx), $sampled(exp_tx)},
                             {16'h0, $sampled(scsi_data_out)});

    a_rd_word : assert property (@(posedge clk) disable iff (!arst_n)
        cpu_rd |-> (cpu_rdata == exp_word))
        else report_mismatch("cpu_rdata", $sampled(exp_word), $sampled(cpu_rdata));

    // latched byte in lanes 0 and 2
    a_mod : assert property (@(posedge clk) disable iff (!arst_n)
        chk_mod |-> (mod_scsi == {8'h00, exp_mod, 8'h00, exp_mod}))
        else report_mismatch("mod_scsi", {8'h00, $sampled(exp_mod), 8'h00, $sampled(exp_mod)},
                             $sampled(mod_scsi));

    initial begin
        logic [31:0] w;
        logic [7:0]  b;
        logic        taken;
        seed         = 32'h8831;
        arst_n       = 1'b0;
        cpu_wdata    = '0;
        cpu_wr       = 1'b0;
        cpu_rd       = 1'b0;
        cpu2s        = 1'b0;
        s2cpu        = 1'b0;
        ls2cpu       = 1'b1;
        a3           = 1'b0;
        dma_go       = 1'b0;
        dma_stop     = 1'b0;
        dir          = DIR_TO_SCSI;
        scsi_req     = 1'b0;
        scsi_data_in = '0;
        chk_idle     = 1'b0;
        chk_tx       = 1'b0;
        exp_tx       = '0;
        exp_word     = '0;
        chk_mod      = 1'b0;
        exp_mod      = '0;
        chk_full     = 1'b0;
        chk_empty    = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        // reset state
        @(posedge clk);
        chk_idle <= 1'b1;
        @(posedge clk);
        chk_idle <= 1'b0;

        // F2S of three host words as twelve bytes
        for (int i = 0; i < 3; i++) begin
            w = $random(seed);
            @(posedge clk);
            cpu_wr    <= 1'b1;
            cpu_wdata <= w;
            for (int j = 0; j < 4; j++) begin
                byte_q.push_back(w[j*8 +: 8]);
            end
        end
        @(posedge clk);
        cpu_wr <= 1'b0;
        pulse_go(DIR_TO_SCSI);
        for (int k = 0; k < 12; k++) begin
            take_tx_byte(byte_q.pop_front());
        end
        @(posedge clk);
        chk_idle <= 1'b1;
        @(posedge clk);
        chk_idle <= 1'b0;
        pulse_stop();

        // S2F until eight words fill the FIFO
        pulse_go(DIR_FROM_SCSI);
        for (int i = 0; i < 32; i++) begin
            b = 8'($random(seed));
            send_rx_byte(b, taken);
            if (!taken) begin
                report_error("FIFO full before eight words were packed");
            end
            byte_q.push_back(b);
        end
        // reqs while full must not land anywhere
        @(posedge clk);
        chk_full <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            send_rx_byte(8'($random(seed)), taken);
        end
        @(posedge clk);
        chk_full <= 1'b0;
        read_packed_word();
        // ninth word into the freed entry
        for (int i = 0; i < 4; i++) begin
            b = 8'($random(seed));
            send_rx_byte(b, taken);
            if (!taken) begin
                report_error("FIFO still full after a host pop");
            end
            byte_q.push_back(b);
        end
        pulse_stop();
        for (int i = 0; i < 8; i++) begin
            read_packed_word();
        end
        @(posedge clk);
        chk_idle <= 1'b1;
        @(posedge clk);
        chk_idle <= 1'b0;

        // programmed write where a3 picks the byte
        w = $random(seed);
        @(posedge clk);
        cpu2s     <= 1'b1;
        a3        <= 1'b0;
        cpu_wdata <= w;
        chk_tx    <= 1'b1;
        exp_tx    <= w[7:0];
        @(posedge clk);
        a3     <= 1'b1;
        exp_tx <= w[23:16];
        @(posedge clk);
        cpu2s  <= 1'b0;
        a3     <= 1'b0;
        chk_tx <= 1'b0;

        // programmed read captured on the falling edge while ls2cpu is low
        b = 8'($random(seed));
        @(posedge clk);
        s2cpu        <= 1'b1;
        scsi_data_in <= {8'h00, b};
        @(posedge clk);
        ls2cpu <= 1'b0;
        @(posedge clk);
        // new bus byte must not reach the latch
        ls2cpu       <= 1'b1;
        scsi_data_in <= {8'h00, ~b};
        chk_mod      <= 1'b1;
        exp_mod      <= b;
        repeat (2) @(posedge clk);
        s2cpu <= 1'b0;
        // clear lands on the next rising edge
        @(posedge clk);
        exp_mod <= '0;
        @(posedge clk);
        chk_mod <= 1'b0;

        // stop drops a half packed word
        pulse_go(DIR_FROM_SCSI);
        for (int i = 0; i < 2; i++) begin
            send_rx_byte(8'($random(seed)), taken);
        end
        @(posedge clk);
        chk_empty <= 1'b1;
        pulse_stop();
        @(posedge clk);
        chk_empty <= 1'b0;
        // next transfer packs from lane 0 again
        pulse_go(DIR_FROM_SCSI);
        for (int i = 0; i < 4; i++) begin
            b = 8'($random(seed));
            send_rx_byte(b, taken);
            if (!taken) begin
                report_error("byte refused after a stop");
            end
            byte_q.push_back(b);
        end
        pulse_stop();
        read_packed_word();
        @(posedge clk);
        chk_idle <= 1'b1;
        @(posedge clk);
        chk_idle <= 1'b0;

        repeat (2) @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
verilog/sdmac_pkg.sv
verilog/dma_fifo.sv
verilog/dma_sequencer.sv
verilog/datapath_scsi.sv
verilog/sdmac_datapath_top.sv
sim/tb_sdmac.sv

// File: Makefile
# Verilator build and run of the SDMAC data path testbench

SIM  := obj_dir/Vtb_sdmac
SRCS := $(wildcard include/*.svh verilog/*.sv sim/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --assert --timescale 1ns/1ps --top-module tb_sdmac \
		-f build.f -Mdir obj_dir -o Vtb_sdmac

# pass only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
